// ==== source/UartPkg.sv ====
package UartPkg;

    // clocks per serial bit.
    typedef logic [15:0] clkDivT;

    typedef logic [7:0] byteT;

    // one received character and its stop-bit status.
    typedef struct packed {
        byteT data;
        logic frameErr;
    } rxWordT;

    typedef enum logic [1:0] {
        RxWait,
        RxHalfBit,
        RxData,
        RxStop
    } rxStateT;

    typedef enum logic [1:0] {
        TxIdle,
        TxStart,
        TxData,
        TxStop
    } txStateT;

endpackage

// ==== source/UartTx.sv ====
`timescale 1ns/1ns

module UartTx (
    input  logic            i_Clk,
    input  logic            i_rst,
    input  UartPkg::clkDivT i_ClksPerBit,
    input  UartPkg::byteT   i_TxData,
    input  logic            i_TxStart,
    output logic            o_UartTx,
    output logic            o_TxBusy
);
    import UartPkg::*;

    txStateT    state;
    clkDivT     clkCount;
    logic [2:0] bitIdx;
    logic       bitDone;
    byteT       txShift;

    assign bitDone = (clkCount == i_ClksPerBit - clkDivT'(1));
    assign o_TxBusy = (state != TxIdle);

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            state <= TxIdle;
            clkCount <= '0;
            bitIdx <= '0;
            o_UartTx <= 1'b1;
        end else begin
            case (state)
                TxIdle: begin
                    clkCount <= '0;
                    bitIdx <= '0;
                    if (i_TxStart) begin
                        state <= TxStart;
                        o_UartTx <= 1'b0;
                    end
                end
                TxStart: begin
                    if (bitDone) begin
                        clkCount <= '0;
                        o_UartTx <= txShift[0];
                        state <= TxData;
                    end else begin
                        clkCount <= clkCount + clkDivT'(1);
                    end
                end
                TxData: begin
                    if (bitDone) begin
                        clkCount <= '0;
                        bitIdx <= bitIdx + 3'd1;
                        if (bitIdx == 3'd7) begin
                            o_UartTx <= 1'b1;
                            state <= TxStop;
                        end else begin
                            o_UartTx <= txShift[0];
                        end
                    end else begin
                        clkCount <= clkCount + clkDivT'(1);
                    end
                end
                TxStop: begin
                    if (bitDone) begin
                        clkCount <= '0;
                        state <= TxIdle;
                    end else begin
                        clkCount <= clkCount + clkDivT'(1);
                    end
                end
                default: begin
                    state <= TxIdle;
                end
            endcase
        end
    end

    // shift already points at the next bit when the line changes.
    always_ff @(posedge i_Clk) begin
        if (state == TxIdle && i_TxStart) begin
            txShift <= i_TxData;
        end else if (bitDone && (state == TxStart || state == TxData)) begin
            txShift <= {1'b0, txShift[7:1]};
        end
    end

endmodule

// ==== source/UartRx.sv ====
`timescale 1ns/1ns

module UartRx (
    input  logic            i_Clk,
    input  logic            i_rst,
    input  UartPkg::clkDivT i_ClksPerBit,
    input  logic            i_UartRx,
    output UartPkg::rxWordT o_Word,
    output logic            o_WordValid
);
    import UartPkg::*;

    rxStateT    state;
    clkDivT     clkCount;
    clkDivT     halfLast;
    clkDivT     bitLast;
    logic [2:0] bitIdx;
    logic       rxMeta;
    logic       rxSync;
    logic       rxPrev;
    logic       startEdge;
    logic       sampleTick;
    byteT       shiftReg;

    assign halfLast = (i_ClksPerBit >> 1) - clkDivT'(1);
    assign bitLast = i_ClksPerBit - clkDivT'(1);
    assign startEdge = !rxSync && rxPrev;
    assign sampleTick = (clkCount == bitLast);

    // two sync stages, then edge history.
    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= i_UartRx;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            state <= RxWait;
            clkCount <= '0;
            bitIdx <= '0;
            o_WordValid <= 1'b0;
        end else begin
            o_WordValid <= 1'b0;
            case (state)
                RxWait: begin
                    clkCount <= '0;
                    bitIdx <= '0;
                    if (startEdge) begin
                        state <= RxHalfBit;
                    end
                end
                RxHalfBit: begin
                    if (clkCount == halfLast) begin
                        clkCount <= '0;
                        // line back high at mid start bit is a glitch.
                        state <= rxSync ? RxWait : RxData;
                    end else begin
                        clkCount <= clkCount + clkDivT'(1);
                    end
                end
                RxData: begin
                    if (sampleTick) begin
                        clkCount <= '0;
                        bitIdx <= bitIdx + 3'd1;
                        if (bitIdx == 3'd7) begin
                            state <= RxStop;
                        end
                    end else begin
                        clkCount <= clkCount + clkDivT'(1);
                    end
                end
                RxStop: begin
                    if (sampleTick) begin
                        clkCount <= '0;
                        o_WordValid <= 1'b1;
                        state <= RxWait;
                    end else begin
                        clkCount <= clkCount + clkDivT'(1);
                    end
                end
                default: begin
                    state <= RxWait;
                end
            endcase
        end
    end

    // lsb arrives first.
    always_ff @(posedge i_Clk) begin
        if (state == RxData && sampleTick) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
        if (state == RxStop && sampleTick) begin
            o_Word.data <= shiftReg;
            o_Word.frameErr <= !rxSync;
        end
    end

endmodule

// ==== source/UartRxFifo.sv ====
`timescale 1ns/1ns

module UartRxFifo #(
    parameter int FifoDepth = 8
) (
    input  logic            i_Clk,
    input  logic            i_rst,
    input  UartPkg::rxWordT i_Word,
    input  logic            i_WordValid,
    input  logic            i_Pop,
    output UartPkg::rxWordT o_Head,
    output logic            o_NotEmpty,
    output logic            o_Overflow
);
    import UartPkg::*;

    localparam int PtrW = $clog2(FifoDepth);
    localparam logic [PtrW:0] FullCount = (PtrW + 1)'(FifoDepth);

    typedef logic [PtrW-1:0] ptrT;

    rxWordT        mem [FifoDepth];
    ptrT           wrPtr;
    ptrT           rdPtr;
    logic [PtrW:0] count;
    logic          isFull;
    logic          doPop;
    logic          doWrite;

    assign o_NotEmpty = (count != '0);
    assign isFull = (count == FullCount);
    assign doPop = i_Pop && o_NotEmpty;
    // a pop on the same edge frees the slot.
    assign doWrite = i_WordValid && (!isFull || doPop);
    assign o_Head = mem[rdPtr];

    always_ff @(posedge i_Clk) begin
        if (doWrite) begin
            mem[wrPtr] <= i_Word;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            o_Overflow <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + ptrT'(1);
            end
            if (doPop) begin
                rdPtr <= rdPtr + ptrT'(1);
            end
            case ({doWrite, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset.
            if (i_WordValid && !doWrite) begin
                o_Overflow <= 1'b1;
            end
        end
    end

endmodule

// ==== source/UartLink.sv ====
`timescale 1ns/1ns

module UartLink #(
    parameter int FifoDepth = 8
) (
    input  logic            i_Clk,
    input  logic            i_rst,
    input  UartPkg::clkDivT i_ClksPerBit,
    input  UartPkg::byteT   i_TxData,
    input  logic            i_TxStart,
    input  logic            i_UartRx,
    input  logic            i_RxPop,
    output logic            o_UartTx,
    output logic            o_TxBusy,
    output UartPkg::rxWordT o_RxWord,
    output logic            o_RxValid,
    output logic            o_RxOverflow
);
    import UartPkg::*;

    rxWordT rxWord;
    logic   rxWordValid;

    UartTx txInst (
        .i_Clk        (i_Clk),
        .i_rst        (i_rst),
        .i_ClksPerBit (i_ClksPerBit),
        .i_TxData     (i_TxData),
        .i_TxStart    (i_TxStart),
        .o_UartTx     (o_UartTx),
        .o_TxBusy     (o_TxBusy)
    );

    UartRx rxInst (
        .i_Clk        (i_Clk),
        .i_rst        (i_rst),
        .i_ClksPerBit (i_ClksPerBit),
        .i_UartRx     (i_UartRx),
        .o_Word       (rxWord),
        .o_WordValid  (rxWordValid)
    );

    // host drains received words at its own pace.
    UartRxFifo #(
        .FifoDepth (FifoDepth)
    ) fifoInst (
        .i_Clk       (i_Clk),
        .i_rst       (i_rst),
        .i_Word      (rxWord),
        .i_WordValid (rxWordValid),
        .i_Pop       (i_RxPop),
        .o_Head      (o_RxWord),
        .o_NotEmpty  (o_RxValid),
        .o_Overflow  (o_RxOverflow)
    );

endmodule

// ==== verification/UartLinkTb.sv ====
`timescale 1ns/1ns

module UartLinkTb;
    import UartPkg::*;

    localparam int FifoDepth = 8;
    localparam int ClkPeriod = 100;

    logic   i_Clk;
    logic   i_rst;
    clkDivT i_ClksPerBit;
    byteT   i_TxData;
    logic   i_TxStart;
    logic   i_UartRx;
    logic   i_RxPop;
    logic   o_UartTx;
    logic   o_TxBusy;
    rxWordT o_RxWord;
    logic   o_RxValid;
    logic   o_RxOverflow;

    // high selects the bit-banger instead of loopback.
    logic        useRaw;
    logic        rawLine;
    logic [63:0] modeQ [$];
    clkDivT      divQ [$];
    byteT        byteQ [$];
    logic        errQ [$];
    longint      limitNs;
    logic        limitReady = 1'b0;

    assign i_UartRx = useRaw ? rawLine : o_UartTx;

    UartLink #(.FifoDepth(FifoDepth)) UUT (.*);

    initial begin
        i_Clk = 1'b0;
        forever #(ClkPeriod / 2) i_Clk = ~i_Clk;
    end

    initial begin
        wait (limitReady);
        #(limitNs);
        $display("timeout: the tests did not finish within %0d ns", limitNs);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    task automatic checkWord(input string name, input rxWordT exp, input rxWordT act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected data %h err %b, actual data %h err %b",
                     name, exp.data, exp.frameErr, act.data, act.frameErr);
            $display("FAIL: see errors above");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "flag mismatch");
        end
    endtask

    function automatic rxWordT makeWord(input byteT data, input logic frameErr);
        rxWordT w;
        w.data = data;
        w.frameErr = frameErr;
        return w;
    endfunction

    // frames sent per data line for the watchdog limit.
    function automatic int framesFor(input logic [63:0] mode);
        case (mode)
            "burst": return FifoDepth;
            "overflow": return FifoDepth + 1;
            "badstop": return 2;
            "busy": return 3;
            default: return 1;
        endcase
    endfunction

    task automatic readTestData();
        int          fd;
        int          n;
        string       line;
        logic [63:0] m;
        clkDivT      d;
        byteT        b;
        logic        e;
        longint      cycles;
        cycles = 0;
        fd = $fopen("verification/UartLinkTestdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("FAIL: see errors above");
            $fatal(1, "no test data");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h %b", m, d, b, e);
                if (line[0] != "#" && n == 4) begin
                    modeQ.push_back(m);
                    divQ.push_back(d);
                    byteQ.push_back(b);
                    errQ.push_back(e);
                    cycles += 12 * longint'(d) * framesFor(m);
                end
            end
            $fclose(fd);
            limitNs = (cycles + 5000) * ClkPeriod;
            limitReady = 1'b1;
        end
    endtask

    task automatic applyReset();
        i_rst <= 1'b1;
        repeat (5) @(posedge i_Clk);
        i_rst <= 1'b0;
    endtask

    task automatic checkResetState(input string name);
        @(negedge i_Clk);
        checkBit({name, " line idle"}, 1'b1, o_UartTx);
        checkBit({name, " busy"}, 1'b0, o_TxBusy);
        checkBit({name, " valid"}, 1'b0, o_RxValid);
        checkBit({name, " overflow"}, 1'b0, o_RxOverflow);
    endtask

    task automatic pulseStart(input byteT data);
        @(posedge i_Clk);
        i_TxData <= data;
        i_TxStart <= 1'b1;
        @(posedge i_Clk);
        i_TxStart <= 1'b0;
    endtask

    task automatic waitTxIdle();
        @(negedge i_Clk);
        while (o_TxBusy) @(negedge i_Clk);
    endtask

    task automatic sendByte(input byteT data);
        pulseStart(data);
        waitTxIdle();
    endtask

    task automatic popExpect(input string name, input rxWordT exp);
        @(negedge i_Clk);
        while (!o_RxValid) @(negedge i_Clk);
        checkWord(name, exp, o_RxWord);
        @(posedge i_Clk);
        i_RxPop <= 1'b1;
        @(posedge i_Clk);
        i_RxPop <= 1'b0;
    endtask

    // start bit, data lsb first, chosen stop level, then idle high.
    task automatic driveRawFrame(input byteT data, input logic stopBit);
        logic [9:0] frame;
        int         i;
        frame = {stopBit, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge i_Clk);
            rawLine <= frame[i];
            repeat (int'(i_ClksPerBit) - 1) @(posedge i_Clk);
        end
        @(posedge i_Clk);
        rawLine <= 1'b1;
        repeat (2 * int'(i_ClksPerBit)) @(posedge i_Clk);
    endtask

    initial begin
        int          t;
        int          k;
        byteT        b;
        logic        e;
        string       name;
        byteT        expQ [$];
        void'($urandom(32'h91867a2d));
        i_ClksPerBit <= 16'd8;
        i_TxData <= '0;
        i_TxStart <= 1'b0;
        i_RxPop <= 1'b0;
        useRaw <= 1'b1;
        rawLine <= 1'b1;
        readTestData();
        applyReset();
        checkResetState("reset");
        for (t = 0; t < modeQ.size(); t++) begin
            b = byteQ[t];
            e = errQ[t];
            name = $sformatf("line %0d", t);
            @(posedge i_Clk);
            i_ClksPerBit <= divQ[t];
            useRaw <= (modeQ[t] == "badstop");
            case (modeQ[t])
                "loop": begin
                    sendByte(b);
                    popExpect({name, " loop"}, makeWord(b, e));
                end
                "badstop": begin
                    driveRawFrame(b, 1'b0);
                    popExpect({name, " bad stop"}, makeWord(b, e));
                    driveRawFrame(~b, 1'b1);
                    popExpect({name, " good stop"}, makeWord(~b, 1'b0));
                end
                "busy": begin
                    pulseStart(b);
                    // second strobe lands mid frame.
                    pulseStart(~b);
                    waitTxIdle();
                    popExpect({name, " busy first"}, makeWord(b, e));
                    repeat (12 * int'(divQ[t])) @(posedge i_Clk);
                    @(negedge i_Clk);
                    checkBit({name, " busy ignored"}, 1'b0, o_RxValid);
                end
                "burst", "overflow": begin
                    expQ = {};
                    expQ.push_back(b);
                    for (k = 1; k < framesFor(modeQ[t]); k++) begin
                        expQ.push_back(byteT'($urandom));
                    end
                    for (k = 0; k < expQ.size(); k++) begin
                        sendByte(expQ[k]);
                    end
                    if (modeQ[t] == "overflow") begin
                        // the extra word hits a full FIFO.
                        @(negedge i_Clk);
                        while (!o_RxOverflow) @(negedge i_Clk);
                    end
                    for (k = 0; k < FifoDepth; k++) begin
                        popExpect($sformatf("%s word %0d", name, k), makeWord(expQ[k], e));
                    end
                    @(negedge i_Clk);
                    checkBit({name, " drained"}, 1'b0, o_RxValid);
                    checkBit({name, " overflow"}, modeQ[t] == "overflow", o_RxOverflow);
                    if (modeQ[t] == "overflow") begin
                        @(posedge i_Clk);
                        applyReset();
                        checkResetState({name, " after reset"});
                    end
                end
                default: begin
                    $display("unknown test mode on data line %0d", t);
                    $display("FAIL: see errors above");
                    $fatal(1, "bad test data");
                end
            endcase
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== UartLink.f ====
source/UartPkg.sv
source/UartTx.sv
source/UartRx.sv
source/UartRxFifo.sv
source/UartLink.sv
verification/UartLinkTb.sv

// ==== verification/UartLinkTestdata.txt ====
# mode divisor(hex) byte(hex) frameErr
# modes are loop, badstop, burst, busy and overflow
loop 0004 a5 0
loop 0008 3c 0
loop 000d 01 0
loop 0010 ff 0
loop 0005 80 0
badstop 0008 5a 1
badstop 000b c3 1
burst 0006 11 0
burst 0009 e7 0
busy 0008 96 0
overflow 0006 72 0
